//--- source/exu_pkg.sv
package exu_pkg;

	// one-hot instruction classes
	localparam int cls_lui    = 0;
	localparam int cls_auipc  = 1;
	localparam int cls_jal    = 2;
	localparam int cls_jalr   = 3;
	localparam int cls_branch = 4;
	localparam int cls_load   = 5;
	localparam int cls_store  = 6;
	localparam int cls_op_imm = 7;
	localparam int cls_op     = 8;
	localparam int cls_csr    = 9;
	localparam int cls_sys    = 10;
	localparam int class_count = 11;

	typedef logic [class_count-1:0] opcode_class_t;

	typedef enum logic [3:0] {
		alu_add   = 4'd0,
		alu_sub   = 4'd1,
		alu_and   = 4'd2,
		alu_xor   = 4'd3,
		alu_or    = 4'd4,
		alu_srl   = 4'd5,
		alu_sra   = 4'd6,
		alu_sll   = 4'd7,
		alu_less  = 4'd8,
		alu_uless = 4'd9
	} alu_op_t;

	// machine csr addresses
	localparam logic [11:0] csr_mstatus = 12'h300;
	localparam logic [11:0] csr_mtvec   = 12'h305;
	localparam logic [11:0] csr_mepc    = 12'h341;
	localparam logic [11:0] csr_mcause  = 12'h342;

	localparam logic [31:0] cause_ecall_m = 32'd11; // ecall from m-mode

	localparam int btb_addr_width = 25; // pc bits kept by the btb

	typedef struct packed {
		opcode_class_t op_class;
		logic [3:0]    rd;
		logic          reg_wen;
		logic [31:0]   src1;
		logic [31:0]   src2;
		logic [31:0]   imm;
		logic [31:0]   pc;
		logic [31:0]   dnpc;     // predicted next pc
		logic [2:0]    funct3;
		logic          funct7_5;
		logic [11:0]   csr_addr;
		logic          is_mret;  // sys class only
	} exu_issue_t;

	typedef struct packed {
		logic [3:0]  rd;
		logic        reg_wen;
		logic [31:0] val;        // write-back value or memory address
		logic        lsu_ren;
		logic        lsu_wen;
		logic [31:0] lsu_data;
	} exu_result_t;

	typedef struct packed {
		logic                      jump_wrong;
		logic [31:0]               jump_addr;
		logic                      btb_wvalid;
		logic [btb_addr_width-1:0] btb_pc;
	} exu_redirect_t;

endpackage

//--- source/exu_alu.sv
`timescale 1ns/100ps

module exu_alu import exu_pkg::*; (
	input  exu_issue_t  issue,
	output logic [31:0] alu_val
);

	logic [31:0] loperand;
	logic [31:0] roperand;
	logic [31:0] sum;
	logic [31:0] diff;
	logic        borrow;
	logic        less;
	logic        uless;
	alu_op_t     op;
	logic        is_arith;

	assign is_arith = issue.op_class[cls_op] | issue.op_class[cls_op_imm];

	always_comb begin
		if (issue.op_class[cls_auipc] | issue.op_class[cls_jal] | issue.op_class[cls_branch])
			loperand = issue.pc;
		else if (issue.op_class[cls_lui])
			loperand = 32'b0;
		else
			loperand = issue.src1; // op, op_imm, jalr, load, store
	end

	assign roperand = issue.op_class[cls_op] ? issue.src2 : issue.imm;

	always_comb begin
		op = alu_add;
		if (is_arith) begin
			case (issue.funct3)
				3'b000: op = (issue.op_class[cls_op] & issue.funct7_5) ? alu_sub : alu_add;
				3'b001: op = alu_sll;
				3'b010: op = alu_less;
				3'b011: op = alu_uless;
				3'b100: op = alu_xor;
				3'b101: op = issue.funct7_5 ? alu_sra : alu_srl;
				3'b110: op = alu_or;
				default: op = alu_and;
			endcase
		end
	end

	assign sum = loperand + roperand;
	assign {borrow, diff} = {1'b0, loperand} - {1'b0, roperand};
	assign uless = borrow;
	// signs differ: the negative side is smaller
	assign less = (loperand[31] ^ roperand[31]) ? loperand[31] : diff[31];

	always_comb begin
		case (op)
			alu_add:   alu_val = sum;
			alu_sub:   alu_val = diff;
			alu_and:   alu_val = loperand & roperand;
			alu_xor:   alu_val = loperand ^ roperand;
			alu_or:    alu_val = loperand | roperand;
			alu_srl:   alu_val = loperand >> roperand[4:0];
			alu_sra:   alu_val = $signed(loperand) >>> roperand[4:0];
			alu_sll:   alu_val = loperand << roperand[4:0];
			alu_less:  alu_val = {31'b0, less};
			alu_uless: alu_val = {31'b0, uless};
			default:   alu_val = 32'b0;
		endcase
	end

endmodule

//--- source/exu_branch.sv
`timescale 1ns/100ps

module exu_branch import exu_pkg::*; (
	input  exu_issue_t  issue,
	output logic        taken,
	output logic [31:0] target
);

	logic [31:0] diff;
	logic        borrow;
	logic        equal;
	logic        less;
	logic        uless;
	logic        cond;
	logic [31:0] jalr_sum;

	assign {borrow, diff} = {1'b0, issue.src1} - {1'b0, issue.src2};
	assign equal = (diff == 32'b0);
	assign uless = borrow;
	assign less = (issue.src1[31] ^ issue.src2[31]) ? issue.src1[31] : diff[31];

	always_comb begin
		case (issue.funct3)
			3'b000:  cond = equal;   // beq
			3'b001:  cond = ~equal;  // bne
			3'b100:  cond = less;    // blt
			3'b101:  cond = ~less;   // bge
			3'b110:  cond = uless;   // bltu
			3'b111:  cond = ~uless;  // bgeu
			default: cond = 1'b0;
		endcase
	end

	assign taken = issue.op_class[cls_jal] | issue.op_class[cls_jalr]
		| (issue.op_class[cls_branch] & cond);

	assign jalr_sum = issue.src1 + issue.imm;

	always_comb begin
		if (issue.op_class[cls_jalr])
			target = {jalr_sum[31:1], 1'b0}; // lsb cleared
		else
			target = issue.pc + issue.imm;
	end

endmodule

//--- source/exu_csr_file.sv
`timescale 1ns/100ps

module exu_csr_file import exu_pkg::*; (
	input               clock,
	input               reset,
	input  exu_issue_t  issue,
	input               accept,
	output logic [31:0] csr_val,
	output logic        csr_jump_en,
	output logic [31:0] csr_jump
);

	logic [31:0] mstatus;
	logic [31:0] mtvec;
	logic [31:0] mepc;
	logic [31:0] mcause;
	logic [31:0] csr_wdata;
	logic        csr_wen;
	logic        ecall_en;

	always_comb begin
		case (issue.csr_addr)
			csr_mstatus: csr_val = mstatus;
			csr_mtvec:   csr_val = mtvec;
			csr_mepc:    csr_val = mepc;
			csr_mcause:  csr_val = mcause;
			default:     csr_val = 32'b0;
		endcase
	end

	// csrrw writes src1, csrrs sets bits
	assign csr_wdata = (issue.funct3 == 3'b010) ? (issue.src1 | csr_val) : issue.src1;
	assign csr_wen = accept & issue.op_class[cls_csr]
		& ((issue.funct3 == 3'b001) | (issue.funct3 == 3'b010));
	assign ecall_en = accept & issue.op_class[cls_sys] & ~issue.is_mret;

	assign csr_jump_en = issue.op_class[cls_sys];
	assign csr_jump = issue.is_mret ? mepc : mtvec;

	always_ff @(posedge clock) begin
		if (reset) begin
			mstatus <= 32'b0;
			mtvec   <= 32'b0;
			mepc    <= 32'b0;
			mcause  <= 32'b0;
		end else if (ecall_en) begin
			mepc   <= issue.pc;
			mcause <= cause_ecall_m;
		end else if (csr_wen) begin
			case (issue.csr_addr)
				csr_mstatus: mstatus <= csr_wdata;
				csr_mtvec:   mtvec   <= csr_wdata;
				csr_mepc:    mepc    <= csr_wdata;
				csr_mcause:  mcause  <= csr_wdata;
				default: ; // unknown address is ignored
			endcase
		end
	end

endmodule

//--- source/exu_ctrl.sv
`timescale 1ns/100ps

module exu_ctrl import exu_pkg::*; (
	input                 clock,
	input                 reset,
	input  exu_issue_t    issue,
	input                 in_valid,
	output logic          in_ready,
	input  [31:0]         alu_val,
	input                 taken,
	input  [31:0]         target,
	input  [31:0]         csr_val,
	input                 csr_jump_en,
	input  [31:0]         csr_jump,
	output logic          accept,
	output exu_result_t   result,
	output logic          out_valid,
	input                 out_ready,
	output exu_redirect_t redirect
);

	logic [31:0] snpc;
	logic [31:0] next_pc;
	logic [31:0] wb_val;
	logic        mispredict;
	logic        need_btb;
	logic        link_en;

	assign in_ready = ~out_valid | out_ready; // single output slot
	assign accept = in_valid & in_ready;

	assign snpc = issue.pc + 32'd4;

	always_comb begin
		if (csr_jump_en)
			next_pc = csr_jump;
		else if (taken)
			next_pc = target;
		else
			next_pc = snpc;
	end

	assign mispredict = (next_pc != issue.dnpc);
	// backward branches and jal are worth caching
	assign need_btb = (issue.op_class[cls_branch] & issue.imm[31]) | issue.op_class[cls_jal];

	assign link_en = issue.op_class[cls_jal] | issue.op_class[cls_jalr];

	always_comb begin
		if (link_en)
			wb_val = snpc;
		else if (issue.op_class[cls_csr])
			wb_val = csr_val;
		else
			wb_val = alu_val; // also the load/store address
	end

	always_ff @(posedge clock) begin
		if (reset)
			out_valid <= 1'b0;
		else if (accept)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			result.rd       <= issue.rd;
			result.reg_wen  <= issue.reg_wen;
			result.val      <= wb_val;
			result.lsu_ren  <= issue.op_class[cls_load];
			result.lsu_wen  <= issue.op_class[cls_store];
			result.lsu_data <= issue.src2;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			redirect.jump_wrong <= 1'b0;
			redirect.btb_wvalid <= 1'b0;
		end else if (accept) begin
			redirect.jump_wrong <= mispredict;
			redirect.jump_addr  <= next_pc;
			redirect.btb_wvalid <= mispredict & need_btb;
			redirect.btb_pc     <= issue.pc[btb_addr_width-1:0];
		end else begin
			redirect.jump_wrong <= 1'b0; // strobes last one cycle
			redirect.btb_wvalid <= 1'b0;
		end
	end

endmodule

//--- source/exu_top.sv
`timescale 1ns/100ps

module exu_top import exu_pkg::*; (
	input                 clock,
	input                 reset,
	input  exu_issue_t    issue,
	input                 in_valid,
	output logic          in_ready,
	output exu_result_t   result,
	output logic          out_valid,
	input                 out_ready,
	output exu_redirect_t redirect
);

	logic [31:0] alu_val;
	logic        taken;
	logic [31:0] target;
	logic [31:0] csr_val;
	logic        csr_jump_en;
	logic [31:0] csr_jump;
	logic        accept;

	exu_ctrl exu_ctrl_inst (
		.clock       (clock),
		.reset       (reset),
		.issue       (issue),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.alu_val     (alu_val),
		.taken       (taken),
		.target      (target),
		.csr_val     (csr_val),
		.csr_jump_en (csr_jump_en),
		.csr_jump    (csr_jump),
		.accept      (accept),
		.result      (result),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.redirect    (redirect)
	);

	exu_alu exu_alu_inst (
		.issue   (issue),
		.alu_val (alu_val)
	);

	exu_branch exu_branch_inst (
		.issue  (issue),
		.taken  (taken),
		.target (target)
	);

	exu_csr_file exu_csr_file_inst (
		.clock       (clock),
		.reset       (reset),
		.issue       (issue),
		.accept      (accept),
		.csr_val     (csr_val),
		.csr_jump_en (csr_jump_en),
		.csr_jump    (csr_jump)
	);

endmodule

//--- sim/exu_tb.sv
`timescale 1ns/100ps

module exu_tb import exu_pkg::*; ();

	localparam int test_count   = 400;
	localparam int clock_period = 4;

	logic          clock;
	logic          reset;
	exu_issue_t    issue;
	logic          in_valid;
	logic          in_ready;
	exu_result_t   result;
	logic          out_valid;
	logic          out_ready;
	exu_redirect_t redirect;

	logic [31:0]   lfsr_state;
	logic [31:0]   model_mstatus;
	logic [31:0]   model_mtvec;
	logic [31:0]   model_mepc;
	logic [31:0]   model_mcause;
	exu_result_t   expected_q[$];
	exu_result_t   exp_result;
	exu_redirect_t exp_redirect;
	logic          accept_prev;  // redirect due this cycle
	logic          slot_full;    // expected out_valid
	logic          fire;
	int            sent;

	exu_top exu_top_inst (
		.clock     (clock),
		.reset     (reset),
		.issue     (issue),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.result    (result),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.redirect  (redirect)
	);

	always #(clock_period / 2) clock = ~clock;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		logic        fb;
		bits = 32'b0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	function automatic logic [31:0] csr_read(input logic [11:0] addr);
		case (addr)
			csr_mstatus: return model_mstatus;
			csr_mtvec:   return model_mtvec;
			csr_mepc:    return model_mepc;
			csr_mcause:  return model_mcause;
			default:     return 32'b0;
		endcase
	endfunction

	function automatic logic [31:0] alu_ref(input exu_issue_t ins);
		logic [31:0]        a;
		logic [31:0]        b;
		logic signed [31:0] sa;
		logic signed [31:0] sb;
		if (ins.op_class[cls_auipc] || ins.op_class[cls_jal] || ins.op_class[cls_branch])
			a = ins.pc;
		else if (ins.op_class[cls_lui])
			a = 32'b0;
		else
			a = ins.src1;
		b = ins.op_class[cls_op] ? ins.src2 : ins.imm;
		sa = a;
		sb = b;
		if (!(ins.op_class[cls_op] || ins.op_class[cls_op_imm]))
			return a + b; // addresses and upper immediates
		case (ins.funct3)
			3'd0: return (ins.op_class[cls_op] && ins.funct7_5) ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, sa < sb};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (ins.funct7_5)
					return sa >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_ref(input exu_issue_t ins);
		case (ins.funct3)
			3'd0: return ins.src1 == ins.src2;
			3'd1: return ins.src1 != ins.src2;
			3'd4: return $signed(ins.src1) < $signed(ins.src2);
			3'd5: return $signed(ins.src1) >= $signed(ins.src2);
			3'd6: return ins.src1 < ins.src2;
			3'd7: return ins.src1 >= ins.src2;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] next_pc_of(input exu_issue_t ins);
		if (ins.op_class[cls_sys])
			return ins.is_mret ? model_mepc : model_mtvec;
		if (ins.op_class[cls_jal])
			return ins.pc + ins.imm;
		if (ins.op_class[cls_jalr])
			return (ins.src1 + ins.imm) & ~32'd1;
		if (ins.op_class[cls_branch] && branch_ref(ins))
			return ins.pc + ins.imm;
		return ins.pc + 32'd4;
	endfunction

	// expected outputs of one instruction, then the csr side effects
	function automatic void reference_step(input exu_issue_t ins, output exu_result_t res,
			output exu_redirect_t red);
		logic [31:0] npc;
		logic [31:0] old;
		logic [31:0] wdata;
		npc = next_pc_of(ins);
		old = csr_read(ins.csr_addr);
		res.rd = ins.rd;
		res.reg_wen = ins.reg_wen;
		if (ins.op_class[cls_jal] || ins.op_class[cls_jalr])
			res.val = ins.pc + 32'd4;
		else if (ins.op_class[cls_csr])
			res.val = old;
		else
			res.val = alu_ref(ins);
		res.lsu_ren = ins.op_class[cls_load];
		res.lsu_wen = ins.op_class[cls_store];
		res.lsu_data = ins.src2;
		red.jump_wrong = (npc != ins.dnpc);
		red.jump_addr = npc;
		red.btb_wvalid = red.jump_wrong
			&& ((ins.op_class[cls_branch] && ins.imm[31]) || ins.op_class[cls_jal]);
		red.btb_pc = ins.pc[btb_addr_width-1:0];
		if (ins.op_class[cls_sys] && !ins.is_mret) begin
			model_mepc = ins.pc;
			model_mcause = cause_ecall_m;
		end else if (ins.op_class[cls_csr] && (ins.funct3 == 3'd1 || ins.funct3 == 3'd2)) begin
			wdata = (ins.funct3 == 3'd2) ? (ins.src1 | old) : ins.src1;
			case (ins.csr_addr)
				csr_mstatus: model_mstatus = wdata;
				csr_mtvec:   model_mtvec = wdata;
				csr_mepc:    model_mepc = wdata;
				csr_mcause:  model_mcause = wdata;
				default: ;
			endcase
		end
	endfunction

	function automatic exu_issue_t random_issue();
		exu_issue_t  ins;
		int          cls;
		logic [31:0] r;
		ins = '0;
		cls = take_bits(4) % class_count;
		ins.op_class[cls] = 1'b1;
		ins.rd = take_bits(4);
		ins.reg_wen = take_bits(1);
		ins.src1 = take_bits(32);
		ins.src2 = (take_bits(2) == 0) ? ins.src1 : take_bits(32); // hit equality
		r = take_bits(30);
		ins.pc = {r[29:0], 2'b00};
		r = take_bits(13);
		if (cls == cls_branch || cls == cls_jal)
			ins.imm = {{19{r[12]}}, r[12:1], 1'b0};
		else
			ins.imm = take_bits(32);
		ins.funct3 = take_bits(3);
		if (cls == cls_branch && ins.funct3[2:1] == 2'b01)
			ins.funct3[1] = 1'b0; // no such branch
		if (cls == cls_csr)
			ins.funct3 = ins.funct3[0] ? 3'd1 : 3'd2;
		ins.funct7_5 = take_bits(1);
		r = take_bits(3);
		case (r[2:0])
			3'd0, 3'd4: ins.csr_addr = csr_mstatus;
			3'd1, 3'd5: ins.csr_addr = csr_mtvec;
			3'd2:       ins.csr_addr = csr_mepc;
			3'd3:       ins.csr_addr = csr_mcause;
			default:    ins.csr_addr = take_bits(12);
		endcase
		if (cls == cls_sys)
			ins.is_mret = take_bits(1);
		ins.dnpc = take_bits(1) ? next_pc_of(ins) : take_bits(32);
		return ins;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		if (got !== expected) begin
			$display("error at %0t: %s is %h, expected %h", $time, name, got, expected);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clock) begin
		if (!reset) begin
			check_value("out_valid", out_valid, slot_full);
			check_value("in_ready", in_ready, !slot_full || out_ready);
			if (accept_prev) begin
				check_value("redirect.jump_wrong", redirect.jump_wrong, exp_redirect.jump_wrong);
				check_value("redirect.jump_addr", redirect.jump_addr, exp_redirect.jump_addr);
				check_value("redirect.btb_wvalid", redirect.btb_wvalid, exp_redirect.btb_wvalid);
				check_value("redirect.btb_pc", redirect.btb_pc, exp_redirect.btb_pc);
			end else begin
				check_value("redirect.jump_wrong", redirect.jump_wrong, 1'b0);
				check_value("redirect.btb_wvalid", redirect.btb_wvalid, 1'b0);
			end
			if (out_valid && out_ready) begin
				if (expected_q.size() == 0) begin
					$display("a result left the stage with no instruction accepted for it");
					$display("Errors found");
					$fatal(1);
				end else begin
					exp_result = expected_q.pop_front();
					check_value("result.rd", result.rd, exp_result.rd);
					check_value("result.reg_wen", result.reg_wen, exp_result.reg_wen);
					check_value("result.val", result.val, exp_result.val);
					check_value("result.lsu_ren", result.lsu_ren, exp_result.lsu_ren);
					check_value("result.lsu_wen", result.lsu_wen, exp_result.lsu_wen);
					check_value("result.lsu_data", result.lsu_data, exp_result.lsu_data);
				end
			end
			if (in_valid && in_ready) begin
				reference_step(issue, exp_result, exp_redirect);
				expected_q.push_back(exp_result);
				accept_prev = 1'b1;
				slot_full = 1'b1;
			end else begin
				accept_prev = 1'b0;
				if (out_ready)
					slot_full = 1'b0;
			end
		end
	end

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		issue = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		lfsr_state = 32'h375f_b912;
		model_mstatus = 32'b0;
		model_mtvec = 32'b0;
		model_mepc = 32'b0;
		model_mcause = 32'b0;
		accept_prev = 1'b0;
		slot_full = 1'b0;
		fire = 1'b0;
		sent = 0;
		repeat (5) @(posedge clock);
		#0.5 reset = 1'b0;
		while (sent < test_count) begin
			@(posedge clock);
			#0.5;
			if (fire)
				in_valid = 1'b0;
			out_ready = (take_bits(2) != 0); // mostly ready
			if (!in_valid && take_bits(2) != 0) begin
				issue = random_issue();
				in_valid = 1'b1;
			end
			@(negedge clock);
			fire = in_valid && in_ready;
			if (fire)
				sent++;
		end
		@(posedge clock);
		#0.5;
		in_valid = 1'b0;
		out_ready = 1'b1;
		repeat (3) @(negedge clock); // drain the output register
		#1;
		if (expected_q.size() != 0) begin
			$display("%0d accepted instructions never left the stage", expected_q.size());
			$display("Errors found");
			$fatal(1);
		end else begin
			$display("No errors");
			$finish;
		end
	end

	initial begin
		#(test_count * 20 * clock_period);
		$display("timeout: the stage stopped accepting or returning instructions");
		$display("Errors found");
		$fatal(1);
	end

endmodule

//--- list.f
source/exu_pkg.sv
source/exu_alu.sv
source/exu_branch.sv
source/exu_csr_file.sv
source/exu_ctrl.sv
source/exu_top.sv
sim/exu_tb.sv

//--- Bender.yml
package:
  name: exu
  description: "Execute stage of a small in-order RV32E core"

dependencies: {}

sources:
  - source/exu_pkg.sv
  - source/exu_alu.sv
  - source/exu_branch.sv
  - source/exu_csr_file.sv
  - source/exu_ctrl.sv
  - source/exu_top.sv
  - target: simulation
    files:
      - sim/exu_tb.sv
